//--- hdl/cnn_init_pkg.sv
package cnn_init_pkg;

    ////////////////////
    // geometry

    parameter int data_width = 16;      // one fp16 element
    parameter int para_x = 4;
    parameter int para_y = 4;
    parameter int kernel_size_max = 3;
    parameter int para_kernel = 2;      // kernels loaded side by side

    parameter int fm_init_words = 18;
    parameter int fm_ram_depth = 32;
    parameter int weight_ram_depth = 32;
    parameter int weight_ram_half = weight_ram_depth / 2;

    ////////////////////
    // word types

    typedef logic [data_width-1:0] elem_t;

    // one tile of para_x by para_y elements
    typedef logic [para_x*para_y*data_width-1:0] fm_word_t;

    // full kernel window for each parallel kernel
    typedef logic [kernel_size_max*kernel_size_max*para_kernel*data_width-1:0] weight_word_t;

    typedef logic [$clog2(fm_ram_depth)-1:0] fm_addr_t;
    typedef logic [$clog2(weight_ram_depth)-1:0] weight_addr_t;

endpackage

//--- hdl/word_ram.sv
`timescale 1ns/1ps

module word_ram #(
    parameter int WIDTH = 256,
    parameter int DEPTH = 32
) (
    input  logic                     clk,
    input  logic                     rst,

    input  logic                     wr_strobe,
    input  logic [$clog2(DEPTH)-1:0] wr_addr,
    input  logic [WIDTH-1:0]         wr_data,
    output logic                     wr_ready,

    input  logic [$clog2(DEPTH)-1:0] rd_addr,
    output logic [WIDTH-1:0]         rd_data
);

    logic [WIDTH-1:0] mem [DEPTH];
    logic             wr_take;

    // one write per strobe, the ready pulse masks a held strobe
    assign wr_take = wr_strobe && !wr_ready;

    ////////////////////
    // write side

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ready <= 1'b0;
        end else begin
            wr_ready <= wr_take;    // single cycle pulse
        end
    end

    always_ff @(posedge clk) begin
        if (wr_take) begin
            mem[wr_addr] <= wr_data;
        end
    end

    ////////////////////
    // read side

    // registered read, one cycle latency
    always_ff @(posedge clk) begin
        rd_data <= mem[rd_addr];
    end

endmodule

//--- hdl/fm_init_writer.sv
`timescale 1ns/1ps

module fm_init_writer #(
    parameter int WORDS = cnn_init_pkg::fm_init_words
) (
    input  logic                  clk,
    input  logic                  rst,

    input  logic                  load,
    input  logic                  init,
    input  cnn_init_pkg::elem_t   fill,

    output logic                  wr_strobe,
    output cnn_init_pkg::fm_addr_t wr_addr,
    output cnn_init_pkg::fm_word_t wr_data,
    input  logic                  wr_ready,

    output logic                  done
);

    localparam int fm_elems = cnn_init_pkg::para_x * cnn_init_pkg::para_y;

    typedef enum logic [1:0] {
        st_idle,
        st_write,
        st_wait_ready
    } state_t;

    state_t state;
    logic   last_word;

    assign last_word = (wr_addr == cnn_init_pkg::fm_addr_t'(WORDS - 1));

    ////////////////////
    // address walk

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= st_idle;
            wr_strobe <= 1'b0;
            wr_addr   <= '0;
            done      <= 1'b0;
        end else if (load) begin
            // restart from word 0, first strobe next cycle
            state     <= st_write;
            wr_strobe <= 1'b0;
            wr_addr   <= '0;
            done      <= 1'b0;
        end else begin
            case (state)
                st_write: begin
                    if (!init) begin
                        state <= st_idle;   // init dropped, stop here
                    end else begin
                        wr_strobe <= 1'b1;
                        state     <= st_wait_ready;
                    end
                end
                st_wait_ready: begin
                    if (wr_ready) begin
                        wr_strobe <= 1'b0;
                        if (last_word) begin
                            done  <= 1'b1;
                            state <= st_idle;
                        end else begin
                            wr_addr <= wr_addr + 1'b1;
                            state   <= st_write;  // one low cycle between strobes
                        end
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    // fill value across the whole tile
    always_ff @(posedge clk) begin
        if (state == st_write) begin
            wr_data <= {fm_elems{fill}};
        end
    end

endmodule

//--- hdl/weight_init_writer.sv
`timescale 1ns/1ps

module weight_init_writer (
    input  logic                        clk,
    input  logic                        rst,

    input  logic                        load,
    input  logic                        init,
    input  cnn_init_pkg::elem_t         fill,

    input  logic                        update_en,
    input  logic                        update_weight,
    input  cnn_init_pkg::weight_addr_t  update_addr,
    input  cnn_init_pkg::elem_t         update_fill,

    output logic                        wr_strobe,
    output cnn_init_pkg::weight_addr_t  wr_addr,
    output cnn_init_pkg::weight_word_t  wr_data,
    input  logic                        wr_ready,

    output logic                        done
);

    localparam int kernel_area = cnn_init_pkg::kernel_size_max * cnn_init_pkg::kernel_size_max;
    localparam int weight_elems = kernel_area * cnn_init_pkg::para_kernel;

    typedef enum logic [1:0] {
        st_idle,
        st_write,
        st_wait_ready
    } state_t;

    state_t                     state;
    logic [1:0]                 blk_idx;    // which kernel block
    logic                       updating;   // single update write in flight
    cnn_init_pkg::weight_addr_t blk_base;

    ////////////////////
    // kernel block bases

    always_comb begin
        case (blk_idx)
            2'd0: blk_base = '0;
            2'd1: blk_base = cnn_init_pkg::weight_addr_t'(kernel_area);
            2'd2: blk_base = cnn_init_pkg::weight_addr_t'(cnn_init_pkg::weight_ram_half);
            default: begin
                blk_base = cnn_init_pkg::weight_addr_t'(cnn_init_pkg::weight_ram_half
                                                        + kernel_area);
            end
        endcase
    end

    ////////////////////
    // control

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= st_idle;
            wr_strobe <= 1'b0;
            wr_addr   <= '0;
            blk_idx   <= '0;
            updating  <= 1'b0;
            done      <= 1'b0;
        end else if (load) begin
            state     <= st_write;
            wr_strobe <= 1'b0;
            blk_idx   <= '0;
            updating  <= 1'b0;
            done      <= 1'b0;
        end else begin
            case (state)
                st_idle: begin
                    // single word update, done level untouched
                    if (update_en && update_weight) begin
                        wr_addr   <= update_addr;
                        wr_strobe <= 1'b1;
                        updating  <= 1'b1;
                        state     <= st_wait_ready;
                    end
                end
                st_write: begin
                    if (!init) begin
                        state <= st_idle;
                    end else begin
                        wr_addr   <= blk_base;
                        wr_strobe <= 1'b1;
                        state     <= st_wait_ready;
                    end
                end
                st_wait_ready: begin
                    if (wr_ready) begin
                        wr_strobe <= 1'b0;
                        if (updating) begin
                            updating <= 1'b0;
                            state    <= st_idle;
                        end else if (blk_idx == 2'd3) begin
                            done  <= 1'b1;  // fourth block written
                            state <= st_idle;
                        end else begin
                            blk_idx <= blk_idx + 1'b1;
                            state   <= st_write;
                        end
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    // payload, init fill or captured update fill
    always_ff @(posedge clk) begin
        if (state == st_write) begin
            wr_data <= {weight_elems{fill}};
        end else if (state == st_idle && update_en && update_weight) begin
            wr_data <= {weight_elems{update_fill}};
        end
    end

endmodule

//--- hdl/init_sequencer.sv
`timescale 1ns/1ps

module init_sequencer (
    input  logic clk,
    input  logic rst,

    input  logic init,
    input  logic fm_done,
    input  logic weight_done,

    output logic load,
    output logic start,
    output logic update_en
);

    typedef enum logic [1:0] {
        st_idle,
        st_loading,
        st_ready
    } state_t;

    state_t state;
    logic   init_q;     // previous init for edge detect

    // updates only pass while nothing is loading
    assign update_en = (state == st_idle) && !init;

    always_ff @(posedge clk) begin
        if (rst) begin
            state  <= st_idle;
            init_q <= 1'b0;
            load   <= 1'b0;
            start  <= 1'b0;
        end else begin
            init_q <= init;
            load   <= 1'b0;
            case (state)
                st_idle: begin
                    if (init && !init_q) begin
                        load  <= 1'b1;
                        state <= st_loading;
                    end
                end
                st_loading: begin
                    if (!init) begin
                        state <= st_idle;           // aborted, no start
                    end else if (!load && fm_done && weight_done) begin
                        // done levels are stale while load is still high
                        start <= 1'b1;
                        state <= st_ready;
                    end
                end
                st_ready: begin
                    if (!init) begin
                        start <= 1'b0;
                        state <= st_idle;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

endmodule

//--- hdl/cnn_init_top.sv
`timescale 1ns/1ps

module cnn_init_top (
    input  logic                       clk,
    input  logic                       rst,

    input  logic                       init,
    output logic                       start,

    input  cnn_init_pkg::elem_t        fm_fill,
    input  cnn_init_pkg::elem_t        weight_fill,

    input  logic                       update_weight,
    input  cnn_init_pkg::weight_addr_t update_addr,
    input  cnn_init_pkg::elem_t        update_fill,

    input  cnn_init_pkg::fm_addr_t     fm_rd_addr,
    output cnn_init_pkg::fm_word_t     fm_rd_data,
    input  cnn_init_pkg::weight_addr_t weight_rd_addr,
    output cnn_init_pkg::weight_word_t weight_rd_data
);

    logic load;
    logic update_en;
    logic fm_done;
    logic weight_done;

    // feature-map write exchange
    logic                       fm_wr_strobe;
    cnn_init_pkg::fm_addr_t     fm_wr_addr;
    cnn_init_pkg::fm_word_t     fm_wr_data;
    logic                       fm_wr_ready;

    // weight write exchange
    logic                       weight_wr_strobe;
    cnn_init_pkg::weight_addr_t weight_wr_addr;
    cnn_init_pkg::weight_word_t weight_wr_data;
    logic                       weight_wr_ready;

    ////////////////////
    // control

    init_sequencer seq_i (
        .clk         (clk),
        .rst         (rst),
        .init        (init),
        .fm_done     (fm_done),
        .weight_done (weight_done),
        .load        (load),
        .start       (start),
        .update_en   (update_en)
    );

    fm_init_writer #(
        .WORDS (cnn_init_pkg::fm_init_words)
    ) fm_wr_i (
        .clk       (clk),
        .rst       (rst),
        .load      (load),
        .init      (init),
        .fill      (fm_fill),
        .wr_strobe (fm_wr_strobe),
        .wr_addr   (fm_wr_addr),
        .wr_data   (fm_wr_data),
        .wr_ready  (fm_wr_ready),
        .done      (fm_done)
    );

    weight_init_writer weight_wr_i (
        .clk           (clk),
        .rst           (rst),
        .load          (load),
        .init          (init),
        .fill          (weight_fill),
        .update_en     (update_en),
        .update_weight (update_weight),
        .update_addr   (update_addr),
        .update_fill   (update_fill),
        .wr_strobe     (weight_wr_strobe),
        .wr_addr       (weight_wr_addr),
        .wr_data       (weight_wr_data),
        .wr_ready      (weight_wr_ready),
        .done          (weight_done)
    );

    ////////////////////
    // memories

    word_ram #(
        .WIDTH ($bits(cnn_init_pkg::fm_word_t)),
        .DEPTH (cnn_init_pkg::fm_ram_depth)
    ) fm_ram_i (
        .clk       (clk),
        .rst       (rst),
        .wr_strobe (fm_wr_strobe),
        .wr_addr   (fm_wr_addr),
        .wr_data   (fm_wr_data),
        .wr_ready  (fm_wr_ready),
        .rd_addr   (fm_rd_addr),
        .rd_data   (fm_rd_data)
    );

    word_ram #(
        .WIDTH ($bits(cnn_init_pkg::weight_word_t)),
        .DEPTH (cnn_init_pkg::weight_ram_depth)
    ) weight_ram_i (
        .clk       (clk),
        .rst       (rst),
        .wr_strobe (weight_wr_strobe),
        .wr_addr   (weight_wr_addr),
        .wr_data   (weight_wr_data),
        .wr_ready  (weight_wr_ready),
        .rd_addr   (weight_rd_addr),
        .rd_data   (weight_rd_data)
    );

endmodule

//--- sim/cnn_init_tb.sv
`timescale 1ns/1ps

module cnn_init_tb;

    localparam int clk_period   = 40;
    localparam int reset_cycles = 16;
    localparam int num_rows     = 10;
    localparam int start_bound  = 200;     // cycles allowed from init to start
    localparam int fm_elems     = cnn_init_pkg::para_x * cnn_init_pkg::para_y;
    localparam int kernel_area  = cnn_init_pkg::kernel_size_max * cnn_init_pkg::kernel_size_max;
    localparam int weight_elems = kernel_area * cnn_init_pkg::para_kernel;
    localparam int cmp_width    = $bits(cnn_init_pkg::weight_word_t);

    typedef enum logic [1:0] {
        op_load,
        op_load_abort,
        op_update,
        op_update_during_init
    } op_t;

    logic                       clk;
    logic                       rst;
    logic                       init;
    logic                       start;
    cnn_init_pkg::elem_t        fm_fill;
    cnn_init_pkg::elem_t        weight_fill;
    logic                       update_weight;
    cnn_init_pkg::weight_addr_t update_addr;
    cnn_init_pkg::elem_t        update_fill;
    cnn_init_pkg::fm_addr_t     fm_rd_addr;
    cnn_init_pkg::fm_word_t     fm_rd_data;
    cnn_init_pkg::weight_addr_t weight_rd_addr;
    cnn_init_pkg::weight_word_t weight_rd_data;

    // stimulus table
    op_t                        op_tab       [num_rows];
    cnn_init_pkg::elem_t        fm_fill_tab  [num_rows];
    cnn_init_pkg::elem_t        w_fill_tab   [num_rows];
    cnn_init_pkg::weight_addr_t upd_addr_tab [num_rows];
    cnn_init_pkg::elem_t        upd_fill_tab [num_rows];

    // shadow copies of both RAMs
    cnn_init_pkg::fm_word_t     fm_shadow     [cnn_init_pkg::fm_ram_depth];
    bit                         fm_valid      [cnn_init_pkg::fm_ram_depth];
    cnn_init_pkg::weight_word_t weight_shadow [cnn_init_pkg::weight_ram_depth];
    bit                         weight_valid  [cnn_init_pkg::weight_ram_depth];

    integer seed;

    cnn_init_top dut_i (
        .clk            (clk),
        .rst            (rst),
        .init           (init),
        .start          (start),
        .fm_fill        (fm_fill),
        .weight_fill    (weight_fill),
        .update_weight  (update_weight),
        .update_addr    (update_addr),
        .update_fill    (update_fill),
        .fm_rd_addr     (fm_rd_addr),
        .fm_rd_data     (fm_rd_data),
        .weight_rd_addr (weight_rd_addr),
        .weight_rd_data (weight_rd_data)
    );

    always #(clk_period / 2) clk = ~clk;

    ////////////////////
    // reporting

    task automatic check(input string name, input logic [cmp_width-1:0] got,
                         input logic [cmp_width-1:0] exp);
        if (got !== exp) begin
            $display("FAILED at %0t ns: %s is %h, expected %h", $time, name, got, exp);
            $display("ERRORS FOUND");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("ERRORS FOUND");
        $fatal(1, "run stopped");
    endtask

    // whole run limited by the table length
    initial begin
        #(clk_period * (reset_cycles + start_bound * num_rows));
        abort_run("timeout waiting for start");
    end

    ////////////////////
    // expected words

    function automatic cnn_init_pkg::fm_word_t fm_word(input cnn_init_pkg::elem_t fill);
        return {fm_elems{fill}};
    endfunction

    function automatic cnn_init_pkg::weight_word_t weight_word(input cnn_init_pkg::elem_t fill);
        return {weight_elems{fill}};
    endfunction

    // kernel block bases 0, k*k, half, half + k*k
    function automatic cnn_init_pkg::weight_addr_t block_base(input int blk);
        int base;
        base = (blk >= 2) ? cnn_init_pkg::weight_ram_half : 0;
        if (blk % 2 == 1) begin
            base = base + kernel_area;
        end
        return cnn_init_pkg::weight_addr_t'(base);
    endfunction

    task automatic set_row(input int r, input op_t op,
                           input cnn_init_pkg::elem_t fmf, input cnn_init_pkg::elem_t wf,
                           input cnn_init_pkg::weight_addr_t addr,
                           input cnn_init_pkg::elem_t fill);
        op_tab[r]       = op;
        fm_fill_tab[r]  = fmf;
        w_fill_tab[r]   = wf;
        upd_addr_tab[r] = addr;
        upd_fill_tab[r] = fill;
    endtask

    task automatic build_table();
        cnn_init_pkg::weight_addr_t rnd_a;
        cnn_init_pkg::weight_addr_t rnd_b;
        rnd_a = cnn_init_pkg::weight_addr_t'($random(seed));
        rnd_b = cnn_init_pkg::weight_addr_t'($random(seed));
        set_row(0, op_update,             16'h0000, 16'h0000, 5'd5,  16'h1111);
        set_row(1, op_load,               16'h3c00, 16'h4000, 5'd0,  16'h0000);
        set_row(2, op_update,             16'h0000, 16'h0000, 5'd9,  16'h1234);  // a block base
        set_row(3, op_update,             16'h0000, 16'h0000, rnd_a, 16'h5678);
        set_row(4, op_update_during_init, 16'h4200, 16'h4400, 5'd5,  16'hdead);
        set_row(5, op_load_abort,         16'haaaa, 16'hbbbb, 5'd0,  16'h0000);
        set_row(6, op_load,               16'h4500, 16'h4600, 5'd0,  16'h0000);
        set_row(7, op_update,             16'h0000, 16'h0000, rnd_b, 16'h9abc);
        set_row(8, op_update,             16'h0000, 16'h0000, 5'd25, 16'hcafe);
        set_row(9, op_load,               16'h3800, 16'h3a00, 5'd0,  16'h0000);
    endtask

    ////////////////////
    // readback against the shadow

    task automatic check_fm_shadow();
        for (int a = 0; a < cnn_init_pkg::fm_ram_depth; a++) begin
            if (fm_valid[a]) begin
                fm_rd_addr = cnn_init_pkg::fm_addr_t'(a);
                @(negedge clk);     // one cycle read latency
                check($sformatf("fm_rd_data[%0d]", a), fm_rd_data, fm_shadow[a]);
            end
        end
    endtask

    task automatic check_weight_shadow();
        for (int a = 0; a < cnn_init_pkg::weight_ram_depth; a++) begin
            if (weight_valid[a]) begin
                weight_rd_addr = cnn_init_pkg::weight_addr_t'(a);
                @(negedge clk);
                check($sformatf("weight_rd_data[%0d]", a), weight_rd_data, weight_shadow[a]);
            end
        end
    endtask

    task automatic shadow_load(input cnn_init_pkg::elem_t fmf, input cnn_init_pkg::elem_t wf);
        for (int a = 0; a < cnn_init_pkg::fm_init_words; a++) begin
            fm_shadow[a] = fm_word(fmf);
            fm_valid[a]  = 1'b1;
        end
        for (int b = 0; b < 4; b++) begin
            weight_shadow[block_base(b)] = weight_word(wf);
            weight_valid[block_base(b)]  = 1'b1;
        end
    endtask

    // partial load leaves these words unknown
    task automatic shadow_forget_load();
        for (int a = 0; a < cnn_init_pkg::fm_init_words; a++) begin
            fm_valid[a] = 1'b0;
        end
        for (int b = 0; b < 4; b++) begin
            weight_valid[block_base(b)] = 1'b0;
        end
    endtask

    ////////////////////
    // stimulus steps

    task automatic raise_init(input cnn_init_pkg::elem_t fmf, input cnn_init_pkg::elem_t wf);
        fm_fill     = fmf;
        weight_fill = wf;
        init        = 1'b1;
    endtask

    task automatic wait_start();
        for (int i = 0; i < start_bound && !start; i++) begin
            @(negedge clk);
        end
        if (!start) begin
            abort_run("timeout waiting for start");
        end
    endtask

    task automatic drop_init();
        check("start", start, 1'b1);
        init = 1'b0;
        @(negedge clk);
        check("start", start, 1'b0);
    endtask

    task automatic pulse_update(input cnn_init_pkg::weight_addr_t addr,
                                input cnn_init_pkg::elem_t fill);
        update_addr   = addr;
        update_fill   = fill;
        update_weight = 1'b1;
        @(negedge clk);
        update_weight = 1'b0;
    endtask

    task automatic run_row(input int r);
        case (op_tab[r])
            op_load: begin
                raise_init(fm_fill_tab[r], w_fill_tab[r]);
                wait_start();
                shadow_load(fm_fill_tab[r], w_fill_tab[r]);
                check_fm_shadow();
                check_weight_shadow();
                drop_init();
            end
            op_load_abort: begin
                raise_init(fm_fill_tab[r], w_fill_tab[r]);
                repeat (6) @(negedge clk);
                init = 1'b0;
                repeat (80) begin       // longer than a full load
                    @(negedge clk);
                    check("start", start, 1'b0);    // no start for an aborted load
                end
                shadow_forget_load();
                check_weight_shadow();
            end
            op_update: begin
                repeat (2) @(negedge clk);
                pulse_update(upd_addr_tab[r], upd_fill_tab[r]);
                repeat (4) @(negedge clk);      // 3 cycle write exchange
                weight_shadow[upd_addr_tab[r]] = weight_word(upd_fill_tab[r]);
                weight_valid[upd_addr_tab[r]]  = 1'b1;
                check_weight_shadow();
            end
            default: begin
                // update pulses while init is high are dropped
                raise_init(fm_fill_tab[r], w_fill_tab[r]);
                repeat (20) @(negedge clk);     // weight walk over, fm walk still going
                pulse_update(upd_addr_tab[r], upd_fill_tab[r]);
                wait_start();
                pulse_update(upd_addr_tab[r], ~upd_fill_tab[r]);
                shadow_load(fm_fill_tab[r], w_fill_tab[r]);
                check_weight_shadow();
                check_fm_shadow();
                drop_init();
            end
        endcase
    endtask

    ////////////////////
    // main sequence

    initial begin
        seed           = 32'h32c7_31b5;
        clk            = 1'b0;
        rst            = 1'b1;
        init           = 1'b0;
        fm_fill        = '0;
        weight_fill    = '0;
        update_weight  = 1'b0;
        update_addr    = '0;
        update_fill    = '0;
        fm_rd_addr     = '0;
        weight_rd_addr = '0;
        for (int a = 0; a < cnn_init_pkg::weight_ram_depth; a++) begin
            weight_valid[a] = 1'b0;
        end
        for (int a = 0; a < cnn_init_pkg::fm_ram_depth; a++) begin
            fm_valid[a] = 1'b0;
        end
        build_table();

        repeat (reset_cycles) @(negedge clk);
        rst = 1'b0;

        repeat (10) begin
            @(negedge clk);
            check("start", start, 1'b0);    // idle with init low
        end

        for (int r = 0; r < num_rows; r++) begin
            run_row(r);
        end
        repeat (4) @(negedge clk);

        $display("NO ERRORS");
        $finish;
    end

endmodule

//--- verilog.f
hdl/cnn_init_pkg.sv
hdl/word_ram.sv
hdl/fm_init_writer.sv
hdl/weight_init_writer.sv
hdl/init_sequencer.sv
hdl/cnn_init_top.sv
sim/cnn_init_tb.sv
